// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_router_mmu -f src.f -o sim_router_mmu
	./obj_dir/sim_router_mmu | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== source/mmu_fsm.sv ====
// mmu sequencer: sram clear, path routing, rf write bursts, rf and ex reads, test abort
`timescale 1ns/1ns
`default_nettype none

module mmu_fsm
    import mmu_pkg::*;
(
    input  wire         clk,
    input  wire         reset_n,

    input  path_t       path,
    input  wire         request_clear_mem,         // aborts whatever runs
    input  wire         data_from_rf_write_strobe,
    input  wire         data_request,              // ex holds until data_ready

    input  wire         addr_at_last,
    input  wire         done,

    output mmu_state_t  mmu_state,
    output logic        mem_clear,
    output logic        test_abort,
    output logic        data_ready,

    // ram_port and timer commands
    output addr_op_t    addr_op,
    output logic [1:0]  wdata_op,
    output logic [2:0]  ctrl_op,
    output logic        capture_rf,
    output logic        capture_ex,
    output logic        start
);

    mmu_state_t state_next;

    logic [1:0] strobe_q;        // [0] sampled strobe, [1] previous sample
    logic       strobe_edge;
    logic       wait_busy;       // timer started and done not yet seen
    logic       incr_started;    // later burst words increment the address
    logic       abort_en;        // a test has run since the last upload

    // one-cycle events from the decode below
    logic ev_clear_start;
    logic ev_clear_done;
    logic ev_written;
    logic ev_burst_end;
    logic ev_ex_path;
    logic ev_abort;

    assign strobe_edge = strobe_q[0] & ~strobe_q[1];

    always_comb
    begin
        state_next     = mmu_state;
        addr_op        = ADDR_HOLD;
        wdata_op       = WDATA_HOLD;
        ctrl_op        = CTRL_OFF;
        capture_rf     = 1'b0;
        capture_ex     = 1'b0;
        start          = 1'b0;
        ev_clear_start = 1'b0;
        ev_clear_done  = 1'b0;
        ev_written     = 1'b0;
        ev_burst_end   = 1'b0;
        ev_ex_path     = 1'b0;
        ev_abort       = 1'b0;

        if (request_clear_mem)
        begin
            state_next     = CLEAR_START;  // wins in every state
            ev_clear_start = 1'b1;
        end
        else
        begin
            case (mmu_state)
                IDLE:
                    state_next = mem_clear ? ROUTE : CLEAR_START;  // clear once after reset
                CLEAR_START:
                begin
                    addr_op  = ADDR_SET_ONES;
                    wdata_op = WDATA_ZERO;
                    if (!wait_busy)                  // let an aborted wait run out
                        state_next = CLEAR_NEXT;
                end
                CLEAR_NEXT:
                begin
                    addr_op    = ADDR_INCREMENT;     // address settles before we falls
                    ctrl_op    = CTRL_SELECT;
                    state_next = CLEAR_WRITE;
                end
                CLEAR_WRITE:
                begin
                    ctrl_op = CTRL_WRITE;
                    if (!wait_busy)
                        start = 1'b1;                // first cycle of the strobe
                    else if (done)
                    begin
                        ctrl_op    = CTRL_SELECT;    // rising we latches the zero
                        state_next = CLEAR_WE_HIGH;
                    end
                end
                CLEAR_WE_HIGH:
                begin
                    ctrl_op = CTRL_SELECT;
                    if (addr_at_last)
                    begin
                        addr_op       = ADDR_SET_ONES;
                        wdata_op      = WDATA_ONES;
                        ctrl_op       = CTRL_OFF;
                        ev_clear_done = 1'b1;
                        state_next    = IDLE;
                    end
                    else
                        state_next = CLEAR_NEXT;
                end
                ROUTE:
                begin
                    case (path)
                        PATH_RF_WRITES_RAM:
                        begin
                            ctrl_op    = CTRL_SELECT;
                            ev_abort   = abort_en;   // upload after a test, once only
                            state_next = RF_WRITE_WAIT_STROBE;
                        end
                        PATH_RF_READS_RAM:
                        begin
                            addr_op    = ADDR_LOAD_RF;
                            ctrl_op    = CTRL_READ;
                            state_next = RF_READ;
                        end
                        PATH_EX_READS_RAM:
                        begin
                            ev_ex_path = 1'b1;       // test running, arm the abort
                            if (data_request)
                            begin
                                addr_op    = ADDR_LOAD_EX;
                                ctrl_op    = CTRL_READ;
                                start      = 1'b1;
                                state_next = EX_READ_ACCESS;
                            end
                        end
                        default: ;                   // null path, sram deselected
                    endcase
                end
                RF_WRITE_WAIT_STROBE:
                begin
                    ctrl_op = CTRL_SELECT;
                    if (path != PATH_RF_WRITES_RAM)
                    begin
                        ctrl_op      = CTRL_OFF;     // burst over, next one starts at rf address
                        ev_burst_end = 1'b1;
                        state_next   = ROUTE;
                    end
                    else if (strobe_edge)
                    begin
                        addr_op    = incr_started ? ADDR_INCREMENT : ADDR_LOAD_RF;
                        wdata_op   = WDATA_RF;
                        ctrl_op    = CTRL_WRITE;
                        start      = 1'b1;
                        state_next = RF_WRITE_STROBE;
                    end
                end
                RF_WRITE_STROBE:
                begin
                    ctrl_op = CTRL_WRITE;            // stretched by the timer
                    if (done)
                    begin
                        ctrl_op    = CTRL_SELECT;
                        state_next = RF_WRITE_END;
                    end
                end
                RF_WRITE_END:
                begin
                    ctrl_op    = CTRL_SELECT;
                    ev_written = 1'b1;
                    state_next = ROUTE;
                end
                RF_READ:
                begin
                    ctrl_op    = CTRL_READ;
                    capture_rf = 1'b1;
                    state_next = ROUTE;
                end
                EX_READ_ACCESS:
                begin
                    ctrl_op = CTRL_READ;
                    if (done)
                    begin
                        capture_ex = 1'b1;           // data_ready follows next cycle
                        state_next = EX_READ_DONE;
                    end
                end
                EX_READ_DONE:
                    state_next = ROUTE;
                default:
                    state_next = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            mmu_state    <= IDLE;
            mem_clear    <= 1'b0;
            test_abort   <= 1'b0;
            data_ready   <= 1'b0;
            strobe_q     <= 2'b11;  // no false edge when rf strobe idles high
            wait_busy    <= 1'b0;
            incr_started <= 1'b0;
            abort_en     <= 1'b0;
        end
        else
        begin
            mmu_state  <= state_next;
            data_ready <= capture_ex;
            test_abort <= ev_abort;
            strobe_q   <= {strobe_q[0], data_from_rf_write_strobe};
            wait_busy  <= start | (wait_busy & ~done);

            if (ev_clear_start || ev_written)
                mem_clear <= 1'b0;  // memory no longer known clear
            else if (ev_clear_done)
                mem_clear <= 1'b1;

            if (ev_written)
                incr_started <= 1'b1;
            else if (ev_burst_end || ev_clear_start)
                incr_started <= 1'b0;

            if (ev_abort)
                abort_en <= 1'b0;
            else if (ev_ex_path)
                abort_en <= 1'b1;
        end
    end

    // ex sees exactly one ready cycle per request
    a_ready_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        data_ready |=> !data_ready);

endmodule

`default_nettype wire

// ==== source/mmu_pkg.sv ====
// memory router package: sequencer states, routing paths and ram_port commands
`default_nettype none

package mmu_pkg;

    // sequencer states, driven out as mmu_state
    typedef enum logic [3:0] {
        IDLE                 = 4'd0,
        CLEAR_START          = 4'd1,
        CLEAR_WRITE          = 4'd2,
        CLEAR_WE_HIGH        = 4'd3,
        CLEAR_NEXT           = 4'd4,
        ROUTE                = 4'd5,
        RF_WRITE_WAIT_STROBE = 4'd6,
        RF_WRITE_STROBE      = 4'd7,
        RF_WRITE_END         = 4'd8,
        RF_READ              = 4'd9,
        EX_READ_ACCESS       = 4'd10,
        EX_READ_DONE         = 4'd11
    } mmu_state_t;

    // routing request, any code not listed here deselects the sram
    typedef enum logic [3:0] {
        PATH_RF_WRITES_RAM = 4'd0,
        PATH_RF_READS_RAM  = 4'd1,
        PATH_EX_READS_RAM  = 4'd5,
        PATH_NULL          = 4'd15
    } path_t;

    // what ram_port does with its address register
    typedef enum logic [2:0] {
        ADDR_HOLD,
        ADDR_LOAD_RF,
        ADDR_LOAD_EX,
        ADDR_INCREMENT,
        ADDR_SET_ONES   // next increment wraps to address zero
    } addr_op_t;

    // write data register commands
    localparam logic [1:0] WDATA_HOLD = 2'd0;
    localparam logic [1:0] WDATA_ZERO = 2'd1;
    localparam logic [1:0] WDATA_RF   = 2'd2;
    localparam logic [1:0] WDATA_ONES = 2'd3;

    // sram control pins as {cs_n, we_n, oe_n}
    localparam logic [2:0] CTRL_OFF    = 3'b111;
    localparam logic [2:0] CTRL_SELECT = 3'b011;  // selected, no access
    localparam logic [2:0] CTRL_READ   = 3'b010;
    localparam logic [2:0] CTRL_WRITE  = 3'b001;

endpackage

`default_nettype wire

// ==== source/ram_port.sv ====
// sram port: address and write data registers, control pins, read capture for rf and ex
`timescale 1ns/1ns
`default_nettype none

module ram_port
    import mmu_pkg::*;
#(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 8
) (
    input  wire                   clk,
    input  wire                   reset_n,

    // commands from the sequencer
    input  addr_op_t              addr_op,
    input  wire  [1:0]            wdata_op,
    input  wire  [2:0]            ctrl_op,     // {cs_n, we_n, oe_n}
    input  wire                   capture_rf,
    input  wire                   capture_ex,
    output logic                  addr_at_last,

    // rf and ex side
    input  wire  [ADDR_WIDTH-1:0] addr_from_rf,
    input  wire  [ADDR_WIDTH-1:0] addr_from_ex,
    input  wire  [DATA_WIDTH-1:0] data_from_rf,
    output logic [ADDR_WIDTH-1:0] addr_to_rf,
    output logic [DATA_WIDTH-1:0] data_to_rf,
    output logic [ADDR_WIDTH-1:0] addr_to_ex,
    output logic [DATA_WIDTH-1:0] data_to_ex,

    // sram pins
    output logic [ADDR_WIDTH-1:0] ram_addr,
    output logic [DATA_WIDTH-1:0] ram_wdata,
    input  wire  [DATA_WIDTH-1:0] ram_rdata,
    output logic                  ram_cs_n,
    output logic                  ram_we_n,
    output logic                  ram_oe_n
);

    assign addr_at_last = &ram_addr;  // highest address, end of the clear loop

    // address register
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            ram_addr <= '1;
        else
        begin
            case (addr_op)
                ADDR_LOAD_RF:   ram_addr <= addr_from_rf;   // rf read or first burst word
                ADDR_LOAD_EX:   ram_addr <= addr_from_ex;
                ADDR_INCREMENT: ram_addr <= ram_addr + 1'b1; // wraps, clear and burst
                ADDR_SET_ONES:  ram_addr <= '1;
                default:        ram_addr <= ram_addr;
            endcase
        end
    end

    // write data register
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            ram_wdata <= '1;
        else
        begin
            case (wdata_op)
                WDATA_ZERO: ram_wdata <= '0;
                WDATA_RF:   ram_wdata <= data_from_rf;  // rf holds it stable around the strobe
                WDATA_ONES: ram_wdata <= '1;
                default:    ram_wdata <= ram_wdata;
            endcase
        end
    end

    // control pins change together, all inactive out of reset
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            {ram_cs_n, ram_we_n, ram_oe_n} <= CTRL_OFF;
        else
            {ram_cs_n, ram_we_n, ram_oe_n} <= ctrl_op;
    end

    // read capture and test start address
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            addr_to_rf <= '1;
            data_to_rf <= '1;
            addr_to_ex <= '1;
            data_to_ex <= '1;
        end
        else
        begin
            addr_to_ex <= addr_from_rf;  // ex takes this as start address when a test runs
            if (capture_rf)
            begin
                addr_to_rf <= ram_addr;  // the address the data really came from
                data_to_rf <= ram_rdata;
            end
            if (capture_ex)
                data_to_ex <= ram_rdata; // stays until the next ex read
        end
    end

    // a write never overlaps a read or a deselected sram
    a_we_safe: assert property (@(posedge clk) disable iff (!reset_n)
        !ram_we_n |-> (!ram_cs_n && ram_oe_n));

endmodule

`default_nettype wire

// ==== source/router_mmu.sv ====
// memory router top: sequencer, wait timer and sram port between rf, ex and one sram
`timescale 1ns/1ns
`default_nettype none

module router_mmu
    import mmu_pkg::*;
#(
    parameter int ADDR_WIDTH  = 6,  // small so the clear stays short
    parameter int DATA_WIDTH  = 8,
    parameter int WAIT_STATES = 2
) (
    input  wire                   clk,
    input  wire                   reset_n,

    input  path_t                 path,
    input  wire                   request_clear_mem,
    output mmu_state_t            mmu_state,
    output logic                  mem_clear,
    output logic                  test_abort,

    // rf side
    input  wire  [ADDR_WIDTH-1:0] addr_from_rf,
    input  wire  [DATA_WIDTH-1:0] data_from_rf,
    input  wire                   data_from_rf_write_strobe,
    output logic [ADDR_WIDTH-1:0] addr_to_rf,
    output logic [DATA_WIDTH-1:0] data_to_rf,

    // ex side
    input  wire  [ADDR_WIDTH-1:0] addr_from_ex,
    input  wire                   data_request,
    output logic                  data_ready,
    output logic [ADDR_WIDTH-1:0] addr_to_ex,
    output logic [DATA_WIDTH-1:0] data_to_ex,

    // sram
    output logic [ADDR_WIDTH-1:0] ram_addr,
    output logic [DATA_WIDTH-1:0] ram_wdata,
    input  wire  [DATA_WIDTH-1:0] ram_rdata,
    output logic                  ram_cs_n,
    output logic                  ram_we_n,
    output logic                  ram_oe_n
);

    addr_op_t   addr_op;
    logic [1:0] wdata_op;
    logic [2:0] ctrl_op;
    logic       capture_rf;
    logic       capture_ex;
    logic       start;
    logic       done;
    logic       addr_at_last;

    mmu_fsm i_mmu_fsm (
        .clk, .reset_n, .path, .request_clear_mem, .data_from_rf_write_strobe,
        .data_request, .addr_at_last, .done, .mmu_state, .mem_clear, .test_abort,
        .data_ready, .addr_op, .wdata_op, .ctrl_op, .capture_rf, .capture_ex, .start
    );

    wait_timer #(.WAIT_STATES(WAIT_STATES)) i_wait_timer (
        .clk, .reset_n, .start, .done
    );

    ram_port #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) i_ram_port (
        .clk, .reset_n, .addr_op, .wdata_op, .ctrl_op, .capture_rf, .capture_ex,
        .addr_at_last, .addr_from_rf, .addr_from_ex, .data_from_rf,
        .addr_to_rf, .data_to_rf, .addr_to_ex, .data_to_ex,
        .ram_addr, .ram_wdata, .ram_rdata, .ram_cs_n, .ram_we_n, .ram_oe_n
    );

endmodule

`default_nettype wire

// ==== source/wait_timer.sv ====
// wait timer: down-counter that stretches the sram write strobe and read access
`timescale 1ns/1ns
`default_nettype none

module wait_timer #(
    parameter int WAIT_STATES = 2
) (
    input  wire  clk,
    input  wire  reset_n,
    input  wire  start,    // one-cycle pulse, loads WAIT_STATES
    output logic done      // high in the cycle the count hits zero
);

    // one spare bit so a zero wait still gets a legal width
    localparam int CW = $clog2(WAIT_STATES + 2);

    logic [CW-1:0] count;

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            count <= '0;
            done  <= 1'b0;
        end
        else
        begin
            // done lands WAIT_STATES+1 cycles after start
            done <= start ? (WAIT_STATES == 0) : (count == CW'(1));
            if (start)
                count <= CW'(WAIT_STATES);
            else if (count != '0)
                count <= count - CW'(1);  // idle at zero until next start
        end
    end

    // sequencer must let a wait run out before starting another
    a_no_restart: assert property (@(posedge clk) disable iff (!reset_n)
        start |-> (count == '0));

endmodule

`default_nettype wire

// ==== src.f ====
source/mmu_pkg.sv
source/wait_timer.sv
source/ram_port.sv
source/mmu_fsm.sv
source/router_mmu.sv
tb/sram_model.sv
tb/tb_router_mmu.sv

// ==== tb/sram_model.sv ====
// sram model: behavioral memory with asynchronous read and a write on the rising edge of we
`timescale 1ns/1ns
`default_nettype none

module sram_model #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 8
) (
    input  wire  [ADDR_WIDTH-1:0] addr,
    input  wire  [DATA_WIDTH-1:0] wdata,
    output logic [DATA_WIDTH-1:0] rdata,
    input  wire                   cs_n,
    input  wire                   we_n,
    input  wire                   oe_n
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // power-up garbage, different at every address so the clear has work to do
    initial
    begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = DATA_WIDTH'(i * 37 + 11);
    end

    assign rdata = (!cs_n && !oe_n) ? mem[addr] : '0;  // bus reads zero when not driven

    // data latched as we goes back high
    always @(posedge we_n)
    begin
        if (!cs_n)
            mem[addr] <= wdata;
    end

endmodule

`default_nettype wire

// ==== tb/tb_router_mmu.sv ====
// memory router testbench driving random rf bursts, rf and ex reads, clears and test abort
`timescale 1ns/1ns
`default_nettype none

module tb_router_mmu
    import mmu_pkg::*;
();

    localparam int ADDR_WIDTH   = 6;
    localparam int DATA_WIDTH   = 8;
    localparam int WAIT_STATES  = 2;
    localparam int DEPTH        = 1 << ADDR_WIDTH;
    localparam int NUM_OPS      = 40;
    localparam int CLEAR_CYCLES = DEPTH * (WAIT_STATES + 4) + 32;  // clear plus zero reads
    localparam int CYCLE_LIMIT  = 3 * CLEAR_CYCLES + NUM_OPS * 64;

    logic                  clk;
    logic                  reset_n;
    path_t                 path;
    logic                  request_clear_mem;
    mmu_state_t            mmu_state;
    logic                  mem_clear;
    logic                  test_abort;
    logic [ADDR_WIDTH-1:0] addr_from_rf;
    logic [DATA_WIDTH-1:0] data_from_rf;
    logic                  data_from_rf_write_strobe;
    logic [ADDR_WIDTH-1:0] addr_to_rf;
    logic [DATA_WIDTH-1:0] data_to_rf;
    logic [ADDR_WIDTH-1:0] addr_from_ex;
    logic                  data_request;
    logic                  data_ready;
    logic [ADDR_WIDTH-1:0] addr_to_ex;
    logic [DATA_WIDTH-1:0] data_to_ex;
    logic [ADDR_WIDTH-1:0] ram_addr;
    logic [DATA_WIDTH-1:0] ram_wdata;
    logic [DATA_WIDTH-1:0] ram_rdata;
    logic                  ram_cs_n;
    logic                  ram_we_n;
    logic                  ram_oe_n;

    logic [DATA_WIDTH-1:0] ref_mem [DEPTH];  // what the sram should hold
    int unsigned seed = 47;
    int          cycles = 0;
    int          abort_pulses = 0;
    int          abort_expected = 0;
    bit          abort_armed = 1'b0;   // ex path seen since the last upload

    router_mmu #(
        .ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .WAIT_STATES(WAIT_STATES)
    ) i_router_mmu (
        .clk, .reset_n, .path, .request_clear_mem, .mmu_state, .mem_clear, .test_abort,
        .addr_from_rf, .data_from_rf, .data_from_rf_write_strobe, .addr_to_rf, .data_to_rf,
        .addr_from_ex, .data_request, .data_ready, .addr_to_ex, .data_to_ex,
        .ram_addr, .ram_wdata, .ram_rdata, .ram_cs_n, .ram_we_n, .ram_oe_n
    );

    sram_model #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) i_sram (
        .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata),
        .cs_n(ram_cs_n), .we_n(ram_we_n), .oe_n(ram_oe_n)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // cycle count, abort pulse count and the run limit
    always @(posedge clk)
    begin
        #1;
        cycles++;
        if (test_abort)
            abort_pulses++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: the router stopped responding after %0d cycles", cycles);
            $display("Regression failed");
            $fatal(1, "run stopped on timeout");
        end
    end

    // lcg that hands out its stronger upper bits
    function automatic int unsigned rand_below(int unsigned n);
        seed = seed * 32'd1103515245 + 32'd12345;
        return (seed >> 16) % n;
    endfunction

    task automatic check(input bit ok, input string msg);
        assert (ok)
        else
        begin
            $display("CHECK FAILED at %0t ns: %s", $time, msg);
            $display("Regression failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // sample and drive 2 ns after the edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_for_state(input mmu_state_t s);
        while (mmu_state != s)
            tick();
    endtask

    // rf reads with the read path held and addr_from_rf moving between reads
    task automatic rf_read(input int count_reads);
        logic [ADDR_WIDTH-1:0] addr;
        path = PATH_RF_READS_RAM;
        for (int n = 0; n < count_reads; n++)
        begin
            addr = ADDR_WIDTH'(rand_below(DEPTH));
            addr_from_rf = addr;
            for (int w = 0; w < WAIT_STATES + 4; w++)
            begin
                tick();
                if (addr_to_rf == addr && data_to_rf == ref_mem[addr])
                    break;
            end
            check(addr_to_rf == addr && data_to_rf == ref_mem[addr],
                $sformatf("rf read at %0h gave %0h:%0h, expected %0h",
                    addr, addr_to_rf, data_to_rf, ref_mem[addr]));
            check(addr_to_ex == addr, "addr_to_ex does not follow addr_from_rf");
        end
        path = PATH_NULL;
        wait_for_state(ROUTE);
    endtask

    task automatic ex_read(input int count_reads);
        logic [ADDR_WIDTH-1:0] addr;
        path = PATH_EX_READS_RAM;
        abort_armed = 1'b1;               // router arms its abort in ROUTE
        for (int n = 0; n < count_reads; n++)
        begin
            addr = ADDR_WIDTH'(rand_below(DEPTH));
            addr_from_ex = addr;
            data_request = 1'b1;          // held until ready
            tick();
            while (!data_ready)
                tick();
            check(data_to_ex == ref_mem[addr],
                $sformatf("ex read at %0h gave %0h, expected %0h",
                    addr, data_to_ex, ref_mem[addr]));
            data_request = 1'b0;
            tick();
            check(!data_ready, "data_ready high for more than one cycle");
        end
        path = PATH_NULL;
        wait_for_state(ROUTE);
    endtask

    task automatic rf_write_burst();
        int                    len;
        logic [ADDR_WIDTH-1:0] addr;
        logic [ADDR_WIDTH-1:0] waddr;
        len  = 1 + int'(rand_below(6));
        addr = ADDR_WIDTH'(rand_below(DEPTH));
        addr_from_rf = addr;              // start address held for the whole burst
        path = PATH_RF_WRITES_RAM;
        if (abort_armed)
            abort_expected++;             // first upload after a test
        abort_armed = 1'b0;
        for (int i = 0; i < len; i++)
        begin
            wait_for_state(RF_WRITE_WAIT_STROBE);
            tick();                       // strobe edges stay WAIT_STATES+6 cycles apart
            data_from_rf = DATA_WIDTH'(rand_below(1 << DATA_WIDTH));
            data_from_rf_write_strobe = 1'b1;
            tick();
            data_from_rf_write_strobe = 1'b0;
            wait_for_state(RF_WRITE_END);  // we has risen so the sram holds the word
            waddr = ADDR_WIDTH'(int'(addr) + i);  // wraps like the address register
            ref_mem[waddr] = data_from_rf;
        end
        wait_for_state(RF_WRITE_WAIT_STROBE);
        path = PATH_NULL;                 // ends the burst so the next one loads its address
        wait_for_state(ROUTE);
        check(!mem_clear, "mem_clear still high after an rf write");
        check(abort_pulses == abort_expected,
            $sformatf("test_abort pulsed %0d times, expected %0d",
                abort_pulses, abort_expected));
    endtask

    task automatic clear_memory(input bit requested);
        if (requested)
        begin
            request_clear_mem = 1'b1;
            tick();
            request_clear_mem = 1'b0;
            check(!mem_clear, "mem_clear did not fall on a clear request");
        end
        while (!mem_clear)
            tick();
        wait_for_state(ROUTE);
        for (int i = 0; i < DEPTH; i++)
            ref_mem[i] = '0;
        rf_read(4);                       // random addresses must read zero
    endtask

    initial
    begin
        reset_n                   = 1'b0;
        path                      = PATH_NULL;
        request_clear_mem         = 1'b0;
        addr_from_rf              = '0;
        data_from_rf              = '0;
        data_from_rf_write_strobe = 1'b0;
        addr_from_ex              = '0;
        data_request              = 1'b0;
        repeat (4)
            tick();
        check(mmu_state == IDLE, "state is not IDLE in reset");
        check(ram_cs_n && ram_we_n && ram_oe_n, "sram control pins active in reset");
        check(!mem_clear && !data_ready && !test_abort, "status outputs high in reset");
        check(&addr_to_rf && &data_to_rf && &addr_to_ex && &data_to_ex,
            "rf and ex outputs not all ones in reset");
        check(&ram_addr && &ram_wdata, "sram address or write data not all ones in reset");
        reset_n = 1'b1;

        clear_memory(1'b0);               // the clear after reset
        for (int op = 0; op < NUM_OPS; op++)
        begin
            if (op == 13 || op == 27)
                clear_memory(1'b1);       // requested in the middle of the traffic
            else
            begin
                case (rand_below(3))
                    0:       rf_write_burst();
                    1:       rf_read(1 + int'(rand_below(3)));
                    default: ex_read(1 + int'(rand_below(3)));
                endcase
            end
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire
